/* src/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // basic widths of the load/store unit
    typedef logic [31:0] virt_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  size_t;
    typedef logic [3:0]  tag_t;

    // store as it leaves execute
    typedef struct packed {
        virt_t addr;
        word_t data;
        strb_t wstrb;
        size_t size;
        tag_t  store_num;
    } st_in_t;

    // write request toward the data cache
    typedef struct packed {
        virt_t addr;
        word_t data;
        strb_t wstrb;
        size_t size;
    } st_req_t;

    // one queue slot, complete means retired by the reorder logic
    typedef struct packed {
        logic  valid;
        logic  complete;
        virt_t addr;
        word_t data;
        strb_t wstrb;
        size_t size;
        tag_t  store_num;
    } st_entry_t;

endpackage

`default_nettype wire

/* src/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue #(
    parameter int DEPTH = 16
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 flush,
    input  logic                                 valid,
    input  lsu_pkg::st_in_t                      st_in,
    input  logic                                 commit_store1_valid,
    input  logic                                 commit_store2_valid,
    input  lsu_pkg::tag_t                        pre_store,
    input  logic                                 drain_take,
    input  logic                                 drain_done,
    output lsu_pkg::st_entry_t [DEPTH-1:0]       entries,
    output logic [$clog2(DEPTH)-1:0]             oldest,
    output logic                                 drain_valid,
    output lsu_pkg::st_req_t                     drain_entry,
    output logic                                 store_buffer_full,
    output logic                                 load_wait
);

    localparam int PW = $clog2(DEPTH);

    // slot payload, written on enqueue only
    lsu_pkg::st_in_t slot_data [DEPTH];
    logic [DEPTH-1:0] slot_valid;
    logic [DEPTH-1:0] slot_complete;

    // each pointer has a wrap bit above the index
    logic [PW:0] tail_ptr;
    logic [PW:0] ret_ptr;
    logic [PW:0] req_ptr;
    logic [PW:0] resp_ptr;

    logic [PW-1:0] tail_idx;
    logic [PW-1:0] ret_idx;
    logic [PW-1:0] ret_idx2;
    logic [PW-1:0] req_idx;
    logic [PW-1:0] resp_idx;

    logic [PW:0] ret_count;
    logic [PW:0] ret_next;
    logic        enq;

    logic [DEPTH-1:0] retire_hit;
    logic [DEPTH-1:0] free_hit;
    logic [DEPTH-1:0] enq_hit;

    assign tail_idx = tail_ptr[PW-1:0];
    assign ret_idx  = ret_ptr[PW-1:0];
    assign ret_idx2 = ret_idx + PW'(1);
    assign req_idx  = req_ptr[PW-1:0];
    assign resp_idx = resp_ptr[PW-1:0];

    // one or two stores retire per cycle
    assign ret_count = (PW+1)'(commit_store1_valid) + (PW+1)'(commit_store2_valid);
    assign ret_next  = ret_ptr + ret_count;

    // flush wins over an entering store
    assign enq = valid && !flush;

    // same index, different lap: every slot from response head to tail is taken
    assign store_buffer_full = (tail_idx == resp_idx) && (tail_ptr[PW] != resp_ptr[PW]);

    assign oldest = resp_idx;

    always_comb begin
        retire_hit = '0;
        free_hit   = '0;
        enq_hit    = '0;
        if (ret_count != '0) begin
            retire_hit[ret_idx] = 1'b1;
        end
        if (ret_count == (PW+1)'(2)) begin
            retire_hit[ret_idx2] = 1'b1;
        end
        if (drain_done) begin
            free_hit[resp_idx] = 1'b1;
        end
        if (enq) begin
            enq_hit[tail_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid    <= '0;
            slot_complete <= '0;
            tail_ptr      <= '0;
            ret_ptr       <= '0;
            req_ptr       <= '0;
            resp_ptr      <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (enq_hit[i]) begin
                    slot_valid[i]    <= 1'b1;
                    slot_complete[i] <= 1'b0;
                end else if (free_hit[i]) begin
                    slot_valid[i]    <= 1'b0;
                    slot_complete[i] <= 1'b0;
                end else if (retire_hit[i]) begin
                    // a store retiring in the flush cycle survives it
                    slot_complete[i] <= 1'b1;
                end else if (flush && !slot_complete[i]) begin
                    slot_valid[i]    <= 1'b0;
                    slot_complete[i] <= 1'b0;
                end
            end

            if (flush) begin
                tail_ptr <= ret_next;
            end else if (valid) begin
                tail_ptr <= tail_ptr + (PW+1)'(1);
            end

            ret_ptr <= ret_next;

            if (drain_take) begin
                req_ptr <= req_ptr + (PW+1)'(1);
            end
            if (drain_done) begin
                resp_ptr <= resp_ptr + (PW+1)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            slot_data[tail_idx] <= st_in;
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            entries[i].valid     = slot_valid[i];
            entries[i].complete  = slot_complete[i];
            entries[i].addr      = slot_data[i].addr;
            entries[i].data      = slot_data[i].data;
            entries[i].wstrb     = slot_data[i].wstrb;
            entries[i].size      = slot_data[i].size;
            entries[i].store_num = slot_data[i].store_num;
        end
    end

    // only retired stores go to the cache
    assign drain_valid = slot_valid[req_idx] && slot_complete[req_idx];

    assign drain_entry.addr  = slot_data[req_idx].addr;
    assign drain_entry.data  = slot_data[req_idx].data;
    assign drain_entry.wstrb = slot_data[req_idx].wstrb;
    assign drain_entry.size  = slot_data[req_idx].size;

    // tag wait, the entering store counts as well
    always_comb begin
        load_wait = valid && (st_in.store_num == pre_store);
        for (int i = 0; i < DEPTH; i++) begin
            if (slot_valid[i] && (slot_data[i].store_num == pre_store)) begin
                load_wait = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/store_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module store_forward #(
    parameter int DEPTH = 16
) (
    input  lsu_pkg::st_entry_t [DEPTH-1:0] entries,
    input  logic [$clog2(DEPTH)-1:0]       oldest,
    input  logic                           valid,
    input  lsu_pkg::st_in_t                st_in,
    input  lsu_pkg::virt_t                 pre_lookup_addr,
    input  lsu_pkg::strb_t                 pre_lookup_wstrb,
    output logic                           pre_load_wait,
    output logic                           data_exist,
    output lsu_pkg::word_t                 lookup_data
);

    localparam int PW = $clog2(DEPTH);

    logic [DEPTH-1:0] slot_match;

    // heap-ordered pick tree, leaves at DEPTH..2*DEPTH-1, root at 1
    logic          node_hit [2*DEPTH-1:1];
    logic [PW-1:0] node_age [2*DEPTH-1:1];
    logic [PW-1:0] node_idx [2*DEPTH-1:1];

    logic          win_hit;
    logic [PW-1:0] win_idx;
    logic          win_cover;

    logic in_match;
    logic in_cover;

    // word address compare only, byte lanes handled by the strobe check
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            slot_match[i] = entries[i].valid
                         && (entries[i].addr[31:2] == pre_lookup_addr[31:2]);
        end
    end

    assign in_match = valid && (st_in.addr[31:2] == pre_lookup_addr[31:2]);
    assign in_cover = (st_in.wstrb & pre_lookup_wstrb) == pre_lookup_wstrb;

    assign pre_load_wait = (|slot_match) || in_match;

    always_comb begin
        logic take_right;

        take_right = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            node_hit[DEPTH+i] = slot_match[i];
            // distance from the oldest live slot, larger is younger
            node_age[DEPTH+i] = PW'(i) - oldest;
            node_idx[DEPTH+i] = PW'(i);
        end
        for (int k = DEPTH - 1; k >= 1; k--) begin
            take_right = node_hit[2*k+1]
                      && (!node_hit[2*k] || (node_age[2*k+1] > node_age[2*k]));
            node_hit[k] = node_hit[2*k] || node_hit[2*k+1];
            node_age[k] = take_right ? node_age[2*k+1] : node_age[2*k];
            node_idx[k] = take_right ? node_idx[2*k+1] : node_idx[2*k];
        end
    end

    assign win_hit   = node_hit[1];
    assign win_idx   = node_idx[1];
    assign win_cover = (entries[win_idx].wstrb & pre_lookup_wstrb) == pre_lookup_wstrb;

    // entering store is younger than anything already queued
    always_comb begin
        if (in_match) begin
            data_exist = in_cover;
        end else begin
            data_exist = win_hit && win_cover;
        end
    end

    always_comb begin
        lookup_data = '0;
        if (data_exist) begin
            if (in_match) begin
                lookup_data = st_in.data;
            end else begin
                lookup_data = entries[win_idx].data;
            end
        end
    end

endmodule

`default_nettype wire

/* src/store_drain.sv */
`timescale 1ns/1ps
`default_nettype none

module store_drain (
    input  logic             clk,
    input  logic             reset,
    input  logic             drain_valid,
    input  lsu_pkg::st_req_t drain_entry,
    input  logic             dcache_addr_ok,
    input  logic             dcache_data_ok,
    output logic             drain_take,
    output logic             drain_done,
    output logic             store_req,
    output lsu_pkg::st_req_t commit_req
);

    logic req_valid;
    logic resp_valid;

    logic req_go;
    logic resp_go;
    logic req_allowin;
    logic resp_allowin;

    // response stage empties on data_ok
    assign resp_go      = resp_valid && dcache_data_ok;
    assign resp_allowin = !resp_valid || resp_go;

    // addr_ok only counts when the response stage has room
    assign req_go      = req_valid && dcache_addr_ok && resp_allowin;
    assign req_allowin = !req_valid || req_go;

    assign drain_take = req_allowin && drain_valid;
    assign drain_done = resp_go;
    assign store_req  = req_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else if (req_allowin) begin
            req_valid <= drain_valid;
        end
    end

    // request fields hold while the cache stalls
    always_ff @(posedge clk) begin
        if (drain_take) begin
            commit_req <= drain_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else if (resp_allowin) begin
            resp_valid <= req_go;
        end
    end

endmodule

`default_nettype wire

/* src/store_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module store_buffer_top #(
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,

    // enqueue from execute
    input  logic             valid,
    input  lsu_pkg::st_in_t  st_in,
    output logic             store_buffer_full,

    // retire from the reorder logic
    input  logic             commit_store1_valid,
    input  logic             commit_store2_valid,

    // load lookup
    input  lsu_pkg::virt_t   pre_lookup_addr,
    input  lsu_pkg::strb_t   pre_lookup_wstrb,
    output logic             data_exist,
    output lsu_pkg::word_t   lookup_data,
    output logic             pre_load_wait,
    input  lsu_pkg::tag_t    pre_store,
    output logic             load_wait,

    // data cache write port
    output logic             store_req,
    output lsu_pkg::st_req_t commit_req,
    input  logic             dcache_addr_ok,
    input  logic             dcache_data_ok
);

    localparam int PW = $clog2(DEPTH);

    lsu_pkg::st_entry_t [DEPTH-1:0] entries;
    logic [PW-1:0]                  oldest;
    logic                           drain_valid;
    lsu_pkg::st_req_t               drain_entry;
    logic                           drain_take;
    logic                           drain_done;

    store_queue #(
        .DEPTH(DEPTH)
    ) u_queue (
        .clk                (clk),
        .reset              (reset),
        .flush              (flush),
        .valid              (valid),
        .st_in              (st_in),
        .commit_store1_valid(commit_store1_valid),
        .commit_store2_valid(commit_store2_valid),
        .pre_store          (pre_store),
        .drain_take         (drain_take),
        .drain_done         (drain_done),
        .entries            (entries),
        .oldest             (oldest),
        .drain_valid        (drain_valid),
        .drain_entry        (drain_entry),
        .store_buffer_full  (store_buffer_full),
        .load_wait          (load_wait)
    );

    store_forward #(
        .DEPTH(DEPTH)
    ) u_forward (
        .entries         (entries),
        .oldest          (oldest),
        .valid           (valid),
        .st_in           (st_in),
        .pre_lookup_addr (pre_lookup_addr),
        .pre_lookup_wstrb(pre_lookup_wstrb),
        .pre_load_wait   (pre_load_wait),
        .data_exist      (data_exist),
        .lookup_data     (lookup_data)
    );

    store_drain u_drain (
        .clk           (clk),
        .reset         (reset),
        .drain_valid   (drain_valid),
        .drain_entry   (drain_entry),
        .dcache_addr_ok(dcache_addr_ok),
        .dcache_data_ok(dcache_data_ok),
        .drain_take    (drain_take),
        .drain_done    (drain_done),
        .store_req     (store_req),
        .commit_req    (commit_req)
    );

endmodule

`default_nettype wire

/* tests/tb_store_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_store_buffer;

    localparam int DEPTH = 16;

    localparam int CYC_ORDER   = 300;
    localparam int CYC_FORWARD = 300;
    localparam int CYC_TAG     = 200;
    localparam int CYC_FLUSH   = 400;
    localparam int CYC_FULL    = 60;
    localparam int CYC_DRAIN   = 100;
    localparam int TOTAL_CYCLES = CYC_ORDER + CYC_FORWARD + CYC_TAG + CYC_FLUSH
                                + CYC_FULL + CYC_DRAIN + 8;

    logic             clk;
    logic             reset;
    logic             flush;
    logic             valid;
    lsu_pkg::st_in_t  st_in;
    logic             store_buffer_full;
    logic             commit_store1_valid;
    logic             commit_store2_valid;
    lsu_pkg::virt_t   pre_lookup_addr;
    lsu_pkg::strb_t   pre_lookup_wstrb;
    logic             data_exist;
    lsu_pkg::word_t   lookup_data;
    logic             pre_load_wait;
    lsu_pkg::tag_t    pre_store;
    logic             load_wait;
    logic             store_req;
    lsu_pkg::st_req_t commit_req;
    logic             dcache_addr_ok;
    logic             dcache_data_ok;

    int seed = 11;
    int errors = 0;
    int checks = 0;
    int test_errors = 0;
    int tests_run = 0;

    // reference queue, oldest first, with a retired flag per store
    lsu_pkg::st_in_t  mq [$];
    bit               mret [$];
    // stores already accepted by the cache but not yet freed
    int               issued;
    logic             pending;
    // request register as the model sees it
    logic             exp_req;
    logic             hold_req;
    lsu_pkg::st_req_t held;

    store_buffer_top #(
        .DEPTH(DEPTH)
    ) DUT (
        .clk                (clk),
        .reset              (reset),
        .flush              (flush),
        .valid              (valid),
        .st_in              (st_in),
        .store_buffer_full  (store_buffer_full),
        .commit_store1_valid(commit_store1_valid),
        .commit_store2_valid(commit_store2_valid),
        .pre_lookup_addr    (pre_lookup_addr),
        .pre_lookup_wstrb   (pre_lookup_wstrb),
        .data_exist         (data_exist),
        .lookup_data        (lookup_data),
        .pre_load_wait      (pre_load_wait),
        .pre_store          (pre_store),
        .load_wait          (load_wait),
        .store_req          (store_req),
        .commit_req         (commit_req),
        .dcache_addr_ok     (dcache_addr_ok),
        .dcache_data_ok     (dcache_data_ok)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // four clock periods per test cycle at most
    initial begin
        #(TOTAL_CYCLES * 4 * 100);
        $display("timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES * 4);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = $random(seed);
        return (r % 32'd100) < pct;
    endfunction

    function automatic lsu_pkg::st_req_t to_req(input lsu_pkg::st_in_t s);
        lsu_pkg::st_req_t q;
        q.addr  = s.addr;
        q.data  = s.data;
        q.wstrb = s.wstrb;
        q.size  = s.size;
        return q;
    endfunction

    // retired stores always form a prefix of the queue
    function automatic int count_retired();
        int n;
        n = 0;
        while (n < mret.size() && mret[n]) begin
            n++;
        end
        return n;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_word(input lsu_pkg::word_t got, input lsu_pkg::word_t exp,
                              input string msg);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_req(input lsu_pkg::st_req_t got, input lsu_pkg::st_req_t exp,
                             input string msg);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic drive_inputs(input int enq_pct, input int ret_pct, input int flush_pct,
                                input int aok_pct, input int dok_pct);
        logic [31:0] r;
        int nret;
        nret = count_retired();
        // cache side, at most one response beyond the request
        dcache_data_ok = pending && chance(dok_pct);
        dcache_addr_ok = store_req && (!pending || dcache_data_ok) && chance(aok_pct);
        commit_store1_valid = (mq.size() > nret) && chance(ret_pct);
        commit_store2_valid = commit_store1_valid && (mq.size() > nret + 1) && chance(50);
        flush = !flush && chance(flush_pct);
        valid = (mq.size() < DEPTH) && chance(enq_pct);
        // four word addresses so lookups hit often
        r = $random(seed);
        st_in.addr      = {28'h0000100, r[3:0]};
        st_in.data      = $random(seed);
        st_in.wstrb     = r[7:4];
        st_in.size      = r[10:8];
        st_in.store_num = r[14:11];
        r = $random(seed);
        pre_lookup_addr  = {28'h0000100, r[3:0]};
        pre_lookup_wstrb = r[7:4];
        pre_store        = r[11:8];
    endtask

    task automatic check_outputs();
        logic in_m;
        logic found;
        logic cov;
        logic exp_wait;
        logic exp_tag;
        int widx;
        lsu_pkg::word_t d;
        in_m     = valid && (st_in.addr[31:2] == pre_lookup_addr[31:2]);
        exp_wait = in_m;
        exp_tag  = valid && (st_in.store_num == pre_store);
        found    = 1'b0;
        widx     = 0;
        for (int i = 0; i < mq.size(); i++) begin
            // later index is younger
            if (mq[i].addr[31:2] == pre_lookup_addr[31:2]) begin
                exp_wait = 1'b1;
                found    = 1'b1;
                widx     = i;
            end
            if (mq[i].store_num == pre_store) begin
                exp_tag = 1'b1;
            end
        end
        cov = 1'b0;
        d   = '0;
        if (in_m) begin
            cov = (st_in.wstrb & pre_lookup_wstrb) == pre_lookup_wstrb;
            d   = st_in.data;
        end else if (found) begin
            cov = (mq[widx].wstrb & pre_lookup_wstrb) == pre_lookup_wstrb;
            d   = mq[widx].data;
        end
        check_bit(store_buffer_full, mq.size() == DEPTH, "store_buffer_full");
        check_bit(load_wait, exp_tag, "load_wait");
        check_bit(pre_load_wait, exp_wait, "pre_load_wait");
        check_bit(data_exist, cov, "data_exist");
        check_word(lookup_data, cov ? d : '0, "lookup_data");
        check_bit(store_req, exp_req, "store_req");
        if (hold_req) begin
            check_req(commit_req, held, "commit_req changed under stall");
        end
        if (store_req && dcache_addr_ok) begin
            if (issued >= mq.size()) begin
                note_error("cache accepted a store that the model does not hold");
            end else begin
                check_bit(mret[issued], 1'b1, "accepted store is retired");
                check_req(commit_req, to_req(mq[issued]), "commit_req in program order");
            end
        end
    endtask

    task automatic update_model();
        logic acc;
        int nret;
        int idx;
        acc  = store_req && dcache_addr_ok;
        nret = count_retired();
        // the store behind the request register loads on this edge
        idx = exp_req ? issued + 1 : issued;
        if (!exp_req || acc) begin
            exp_req = (idx < mq.size()) && mret[idx];
        end
        if (commit_store1_valid) begin
            mret[nret] = 1'b1;
        end
        if (commit_store2_valid) begin
            mret[nret+1] = 1'b1;
        end
        if (dcache_data_ok) begin
            void'(mq.pop_front());
            void'(mret.pop_front());
            issued--;
        end
        if (acc) begin
            issued++;
        end
        pending  = acc || (pending && !dcache_data_ok);
        hold_req = store_req && !acc;
        held     = commit_req;
        if (flush) begin
            // unretired stores sit at the young end
            while (mret.size() > 0 && !mret[mret.size()-1]) begin
                void'(mq.pop_back());
                void'(mret.pop_back());
            end
        end else if (valid) begin
            mq.push_back(st_in);
            mret.push_back(1'b0);
        end
    endtask

    task automatic run_test(input string name, input int cycles, input int enq_pct,
                            input int ret_pct, input int flush_pct, input int aok_pct,
                            input int dok_pct);
        test_errors = 0;
        for (int n = 0; n < cycles; n++) begin
            drive_inputs(enq_pct, ret_pct, flush_pct, aok_pct, dok_pct);
            @(negedge clk);
            check_outputs();
            update_model();
            @(posedge clk);
            #1;
        end
        tests_run++;
        $display("test %0d %s: %0d cycles, %0d errors", tests_run, name, cycles, test_errors);
    endtask

    initial begin
        reset               = 1'b1;
        flush               = 1'b0;
        valid               = 1'b0;
        st_in               = '0;
        commit_store1_valid = 1'b0;
        commit_store2_valid = 1'b0;
        pre_lookup_addr     = '0;
        pre_lookup_wstrb    = '0;
        pre_store           = '0;
        dcache_addr_ok      = 1'b0;
        dcache_data_ok      = 1'b0;
        issued              = 0;
        pending             = 1'b0;
        exp_req             = 1'b0;
        hold_req            = 1'b0;
        held                = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        test_errors = 0;
        check_bit(store_req, 1'b0, "store_req after reset");
        check_bit(store_buffer_full, 1'b0, "store_buffer_full after reset");
        tests_run++;
        $display("test %0d reset state: %0d errors", tests_run, test_errors);
        @(posedge clk);
        #1;

        run_test("drain order", CYC_ORDER, 60, 50, 0, 60, 60);
        run_test("forwarding", CYC_FORWARD, 70, 20, 0, 30, 40);
        run_test("tag wait", CYC_TAG, 50, 40, 0, 50, 50);
        run_test("flush", CYC_FLUSH, 60, 40, 8, 50, 50);
        // cache held off so the queue fills up
        run_test("full under stall", CYC_FULL, 90, 50, 0, 0, 0);
        run_test("drain after stall", CYC_DRAIN, 0, 100, 0, 80, 80);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/lsu_pkg.sv
src/store_queue.sv
src/store_forward.sv
src/store_drain.sv
src/store_buffer_top.sv
tests/tb_store_buffer.sv

/* run.sh */
#!/usr/bin/env bash
# builds the store buffer testbench with Verilator and runs it into sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing -j 0 --top-module tb_store_buffer -f project.f \
    --Mdir obj_dir -o tb_store_buffer > build.log 2>&1 \
    && ./obj_dir/tb_store_buffer > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "SIMULATION FAILED" sim.log \
    && { echo "store buffer test failed, see sim.log"; exit 1; } \
    || { echo "store buffer test passed"; exit 0; }
